// File: fma_defines.svh
`ifndef FMA_DEFINES_SVH
`define FMA_DEFINES_SVH

// fp32 field layout
`define FMA_FP_WIDTH   32
`define FMA_EXP_WIDTH  8
`define FMA_MANT_WIDTH 23
`define FMA_BIAS       127

// full 24x24 significand product
`define FMA_PROD_WIDTH 48

// alignment bits below the product lsb
`define FMA_GUARD_BITS 3

// canonical indefinite nan
`define FMA_QNAN_INDEF 32'hffc0_0000

`endif

// File: fp_pkg.sv
`include "fma_defines.svh"

package fp_pkg;

    typedef struct packed {
        logic                       sign;
        logic [`FMA_EXP_WIDTH-1:0]  exp;
        logic [`FMA_MANT_WIDTH-1:0] mant;
    } fp_encoding_t;

    // subnormals are reported as zero
    typedef struct packed {
        logic is_zero;
        logic is_inf;
        logic is_nan;
        logic is_signalling;
        logic is_normal;
        logic is_minus;
    } fp_class_t;

    typedef enum logic [2:0] {
        RNE = 3'b000,
        RTZ = 3'b001,
        RDN = 3'b010,
        RUP = 3'b011,
        RMM = 3'b100
    } roundmode_e;

    function automatic fp_class_t fp_classify(input fp_encoding_t enc);
        fp_class_t cls;
        logic      exp_ones;
        logic      exp_zero;
        logic      mant_zero;
        exp_ones          = &enc.exp;
        exp_zero          = ~|enc.exp;
        mant_zero         = ~|enc.mant;
        cls.is_zero       = exp_zero;
        cls.is_inf        = exp_ones & mant_zero;
        cls.is_nan        = exp_ones & ~mant_zero;
        // quiet bit clear means signalling
        cls.is_signalling = cls.is_nan & ~enc.mant[`FMA_MANT_WIDTH-1];
        cls.is_normal     = ~exp_zero & ~exp_ones;
        cls.is_minus      = enc.sign;
        return cls;
    endfunction

endpackage

// File: fma_pkg.sv
`include "fma_defines.svh"

package fma_pkg;

    // special-case class decided once in the multiply stage
    typedef enum logic [2:0] {
        CASE_FINITE,
        CASE_NAN_A,
        CASE_NAN_B,
        CASE_NAN_C,
        CASE_INVALID,
        CASE_INF_PROD,
        CASE_INF_C,
        CASE_ZERO_PROD
    } fma_case_e;

    // product handed from multiply stage to add stage
    typedef struct packed {
        logic                              sign;
        // biased, signed, two bits of carry room
        logic signed [`FMA_EXP_WIDTH+1:0]  exp;
        // hidden bit at the msb
        logic [`FMA_PROD_WIDTH-1:0]        mant;
        fma_case_e                         fcase;
        // holds the nan operand for the nan cases
        fp_pkg::fp_encoding_t              c;
        logic                              c_sign;
        logic                              zero_sign;
        logic                              invalid;
    } fma_prod_t;

endpackage

// File: fma_prod_if.sv
`timescale 1ns/100ps

interface fma_prod_if (
    input logic clk_i,
    input logic arst_n_i
);
    import fma_pkg::*;

    logic      valid;
    // meaningful only while valid is high
    fma_prod_t payload;

    modport mul_mp (
        input  clk_i,
        input  arst_n_i,
        output valid,
        output payload
    );

    modport add_mp (
        input  clk_i,
        input  arst_n_i,
        input  valid,
        input  payload
    );

endinterface

// File: lzc.sv
`timescale 1ns/100ps

module lzc #(
    parameter  int WIDTH     = 32,
    localparam int CNT_WIDTH = $clog2(WIDTH + 1)
) (
    input  logic [WIDTH-1:0]     a_i,
    output logic [CNT_WIDTH-1:0] cnt_o,
    output logic                 zero_o
);

    // highest set bit wins, scanning up from the lsb
    always_comb
    begin
        cnt_o = CNT_WIDTH'(WIDTH);
        for (int i = 0; i < WIDTH; i++)
        begin
            if (a_i[i])
                cnt_o = CNT_WIDTH'(WIDTH - 1 - i);
        end
    end

    assign zero_o = ~|a_i;

    // count saturates at WIDTH only for an all-zero input
    always_comb
    begin
        assert final ((cnt_o <= WIDTH) && (zero_o == (cnt_o == CNT_WIDTH'(WIDTH))))
            else $error("lzc count out of range");
    end

endmodule

// File: fma_mul_stage.sv
`timescale 1ns/100ps
`include "fma_defines.svh"

module fma_mul_stage (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     valid_i,
    input  logic [`FMA_FP_WIDTH-1:0] a_i,
    input  logic [`FMA_FP_WIDTH-1:0] b_i,
    input  logic [`FMA_FP_WIDTH-1:0] c_i,
    input  logic                     sub_i,
    input  fp_pkg::roundmode_e       rnd_i,
    fma_prod_if.mul_mp               prod_o
);
    import fp_pkg::*;
    import fma_pkg::*;

    localparam int PW = `FMA_PROD_WIDTH;
    localparam int EW = `FMA_EXP_WIDTH + 2;
    localparam int LW = $clog2(PW);

    fp_encoding_t         a_enc;
    fp_encoding_t         b_enc;
    fp_encoding_t         c_enc;
    fp_class_t            a_cls;
    fp_class_t            b_cls;
    fp_class_t            c_cls;
    logic [PW-1:0]        raw_mant;
    logic [PW-1:0]        norm_mant;
    logic [LW-1:0]        shamt;
    logic signed [EW-1:0] raw_exp;
    logic signed [EW-1:0] norm_exp;
    logic                 prod_sign;
    logic                 c_eff_sign;
    logic                 prod_inf;
    fma_case_e            prod_case;
    fma_prod_t            prod_d;

    assign a_enc = a_i;
    assign b_enc = b_i;
    assign c_enc = c_i;
    assign a_cls = fp_classify(a_i);
    assign b_cls = fp_classify(b_i);
    assign c_cls = fp_classify(c_i);

    assign prod_sign  = a_cls.is_minus ^ b_cls.is_minus;
    assign c_eff_sign = c_cls.is_minus ^ sub_i;

    //////////////////////////////////////////////////
    // multiply and normalize
    //////////////////////////////////////////////////
    assign raw_mant = {a_cls.is_normal, a_enc.mant} * {b_cls.is_normal, b_enc.mant};
    assign raw_exp  = EW'(a_enc.exp) + EW'(b_enc.exp) - EW'(`FMA_BIAS);

    lzc #(.WIDTH(PW - 1)) mul_lzc_inst (
        .a_i    (raw_mant[PW-2:0]),
        .cnt_o  (shamt),
        .zero_o ()
    );

    // product in [1,4), hidden bit ends up at the msb
    always_comb
    begin
        if (raw_mant[PW-1])
        begin
            norm_mant = raw_mant;
            norm_exp  = raw_exp + EW'(1);
        end
        else
        begin
            norm_mant = {raw_mant[PW-2:0] << shamt, 1'b0};
            norm_exp  = raw_exp - $signed(EW'(shamt));
        end
    end

    //////////////////////////////////////////////////
    // special cases
    //////////////////////////////////////////////////
    assign prod_inf = (a_cls.is_inf | b_cls.is_inf) & ~(a_cls.is_nan | b_cls.is_nan)
                    & ~(a_cls.is_zero | b_cls.is_zero);

    always_comb
    begin
        if ((a_cls.is_inf & b_cls.is_zero) | (a_cls.is_zero & b_cls.is_inf)
            | (prod_inf & c_cls.is_inf & (prod_sign ^ c_eff_sign)))
            prod_case = CASE_INVALID;
        else if (a_cls.is_nan)
            prod_case = CASE_NAN_A;
        else if (b_cls.is_nan)
            prod_case = CASE_NAN_B;
        else if (c_cls.is_nan)
            prod_case = CASE_NAN_C;
        else if (prod_inf)
            prod_case = CASE_INF_PROD;
        else if (c_cls.is_inf)
            prod_case = CASE_INF_C;
        else if (a_cls.is_zero | b_cls.is_zero)
            prod_case = CASE_ZERO_PROD;
        else
            prod_case = CASE_FINITE;
    end

    always_comb
    begin
        prod_d.sign  = prod_sign;
        prod_d.exp   = norm_exp;
        prod_d.mant  = norm_mant;
        prod_d.fcase = prod_case;
        // nan operand rides in the c slot
        case (prod_case)
            CASE_NAN_A: prod_d.c = a_enc;
            CASE_NAN_B: prod_d.c = b_enc;
            default:    prod_d.c = c_enc;
        endcase
        prod_d.c_sign    = c_eff_sign;
        prod_d.zero_sign = (rnd_i == RDN);
        prod_d.invalid   = a_cls.is_signalling | b_cls.is_signalling | c_cls.is_signalling
                         | (prod_case == CASE_INVALID);
    end

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
            prod_o.valid <= 1'b0;
        else
            prod_o.valid <= valid_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (valid_i)
            prod_o.payload <= prod_d;
    end

    // the add stage relies on a normalized product
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (prod_o.valid && (prod_o.payload.fcase == CASE_FINITE)) |-> prod_o.payload.mant[PW-1])
        else $error("finite product not normalized");

endmodule

// File: fma_add_stage.sv
`timescale 1ns/100ps
`include "fma_defines.svh"

module fma_add_stage (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    fma_prod_if.add_mp               prod_i,
    output logic                     valid_o,
    output logic [`FMA_FP_WIDTH-1:0] result_o,
    output logic [1:0]               round_sticky_o,
    output logic                     invalid_o,
    output logic                     overflow_o
);
    import fp_pkg::*;
    import fma_pkg::*;

    localparam int PW      = `FMA_PROD_WIDTH;
    localparam int GB      = `FMA_GUARD_BITS;
    localparam int MW      = `FMA_MANT_WIDTH;
    localparam int EW      = `FMA_EXP_WIDTH + 2;
    localparam int AW      = PW + GB;
    localparam int SW      = AW + 2;
    localparam int HW      = (SW - 1) / 2;
    localparam int CW      = $clog2(HW + 1);
    localparam int LZW     = $clog2(SW);
    localparam int RB      = SW - 3 - MW;
    localparam int EXP_MAX = (1 << `FMA_EXP_WIDTH) - 1;

    fma_prod_t            pr;
    fp_class_t            c_cls;
    logic signed [EW-1:0] p_exp;
    logic signed [EW-1:0] c_exp;
    logic signed [EW-1:0] big_exp;
    logic signed [EW-1:0] small_exp;
    logic signed [EW-1:0] norm_exp;
    logic [EW-1:0]        exp_diff;
    logic [AW-1:0]        p_ext;
    logic [AW-1:0]        c_ext;
    logic [AW-1:0]        big_m;
    logic [AW-1:0]        small_m;
    logic [AW-1:0]        small_sh;
    logic [AW-1:0]        shifted_out;
    logic [SW-1:0]        sum;
    logic [SW-2:0]        norm_m;
    logic [CW-1:0]        hi_cnt;
    logic [CW-1:0]        lo_cnt;
    logic [LZW-1:0]       lz;
    logic                 hi_zero;
    logic                 lo_zero;
    logic                 swap;
    logic                 eff_sub;
    logic                 big_sign;
    logic                 align_sticky;
    logic                 drop;
    logic                 sum_zero;
    fp_encoding_t         res_d;
    logic [1:0]           rs_d;
    logic                 ovf_d;

    assign pr    = prod_i.payload;
    assign c_cls = fp_classify(pr.c);
    assign p_exp = pr.exp;
    assign c_exp = {2'b00, pr.c.exp};

    //////////////////////////////////////////////////
    // align
    //////////////////////////////////////////////////
    assign p_ext = {pr.mant, {GB{1'b0}}};
    assign c_ext = c_cls.is_zero ? '0 : {1'b1, pr.c.mant, {(AW - MW - 1){1'b0}}};

    // larger magnitude stays put, a zero c never does
    assign swap = ~c_cls.is_zero
                & ((c_exp > p_exp) || ((c_exp == p_exp) && (c_ext > p_ext)));

    assign big_m     = swap ? c_ext : p_ext;
    assign small_m   = swap ? p_ext : c_ext;
    assign big_exp   = swap ? c_exp : p_exp;
    assign small_exp = swap ? p_exp : c_exp;
    assign big_sign  = swap ? pr.c_sign : pr.sign;
    assign exp_diff  = big_exp - small_exp;

    assign {small_sh, shifted_out} = {small_m, {AW{1'b0}}} >> exp_diff;
    // a far smaller operand leaves the window entirely
    assign align_sticky = (exp_diff > EW'(AW)) ? |small_m : |shifted_out;

    assign eff_sub = pr.sign ^ pr.c_sign;
    assign sum = eff_sub ? ({1'b0, big_m, 1'b0} - {1'b0, small_sh, align_sticky})
                         : ({1'b0, big_m, 1'b0} + {1'b0, small_sh, align_sticky});

    //////////////////////////////////////////////////
    // normalize
    //////////////////////////////////////////////////
    lzc #(.WIDTH(HW)) hi_lzc_inst (
        .a_i    (sum[SW-2:HW]),
        .cnt_o  (hi_cnt),
        .zero_o (hi_zero)
    );

    lzc #(.WIDTH(HW)) lo_lzc_inst (
        .a_i    (sum[HW-1:0]),
        .cnt_o  (lo_cnt),
        .zero_o (lo_zero)
    );

    assign lz       = hi_zero ? (LZW'(HW) + LZW'(lo_cnt)) : LZW'(hi_cnt);
    assign sum_zero = hi_zero & lo_zero & ~sum[SW-1];

    always_comb
    begin
        if (sum[SW-1])
        begin
            norm_m   = sum[SW-1:1];
            norm_exp = big_exp + EW'(1);
            drop     = sum[0];
        end
        else
        begin
            norm_m   = sum[SW-2:0] << lz;
            norm_exp = big_exp - $signed(EW'(lz));
            drop     = 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // result select
    //////////////////////////////////////////////////
    always_comb
    begin
        res_d = '0;
        rs_d  = 2'b00;
        ovf_d = 1'b0;
        case (pr.fcase)
            CASE_NAN_A, CASE_NAN_B, CASE_NAN_C:
            begin
                res_d      = pr.c;
                res_d.mant = {1'b1, pr.c.mant[MW-2:0]};
            end
            CASE_INVALID:
                res_d = `FMA_QNAN_INDEF;
            CASE_INF_PROD:
            begin
                res_d.sign = pr.sign;
                res_d.exp  = '1;
            end
            CASE_INF_C:
            begin
                res_d.sign = pr.c_sign;
                res_d.exp  = '1;
            end
            CASE_ZERO_PROD:
            begin
                if (!c_cls.is_zero)
                    res_d = {pr.c_sign, pr.c.exp, pr.c.mant};
                else if (pr.sign == pr.c_sign)
                    res_d.sign = pr.sign;
                else
                    res_d.sign = pr.zero_sign;
            end
            default:
            begin
                if (sum_zero)
                    res_d.sign = pr.zero_sign;
                else if (norm_exp >= EXP_MAX)
                begin
                    res_d.sign = big_sign;
                    res_d.exp  = '1;
                    ovf_d      = 1'b1;
                end
                else if (norm_exp > 0)
                begin
                    res_d.sign = big_sign;
                    res_d.exp  = norm_exp[`FMA_EXP_WIDTH-1:0];
                    res_d.mant = norm_m[SW-3 -: MW];
                    rs_d       = {norm_m[RB], (|norm_m[RB-1:0]) | drop | align_sticky};
                end
                else
                    // below the normal range, flushed
                    res_d.sign = big_sign;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            valid_o    <= 1'b0;
            invalid_o  <= 1'b0;
            overflow_o <= 1'b0;
        end
        else
        begin
            valid_o    <= prod_i.valid;
            invalid_o  <= prod_i.valid & pr.invalid;
            overflow_o <= prod_i.valid & ovf_d;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (prod_i.valid)
        begin
            result_o       <= res_d;
            round_sticky_o <= rs_d;
        end
    end

    // invalid is decided upstream, overflow here
    assert property (@(posedge clk_i) disable iff (!arst_n_i) !(invalid_o && overflow_o))
        else $error("invalid and overflow raised together");

endmodule

// File: fma_top.sv
`timescale 1ns/100ps
`include "fma_defines.svh"

module fma_top (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     valid_i,
    input  logic [`FMA_FP_WIDTH-1:0] a_i,
    input  logic [`FMA_FP_WIDTH-1:0] b_i,
    input  logic [`FMA_FP_WIDTH-1:0] c_i,
    input  logic                     sub_i,
    input  fp_pkg::roundmode_e       rnd_i,
    output logic                     valid_o,
    output logic [`FMA_FP_WIDTH-1:0] result_o,
    output logic [1:0]               round_sticky_o,
    output logic                     invalid_o,
    output logic                     overflow_o
);

    // product register between the two stages
    fma_prod_if prod_if_inst (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i)
    );

    fma_mul_stage mul_stage_inst (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (valid_i),
        .a_i      (a_i),
        .b_i      (b_i),
        .c_i      (c_i),
        .sub_i    (sub_i),
        .rnd_i    (rnd_i),
        .prod_o   (prod_if_inst.mul_mp)
    );

    fma_add_stage add_stage_inst (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .prod_i         (prod_if_inst.add_mp),
        .valid_o        (valid_o),
        .result_o       (result_o),
        .round_sticky_o (round_sticky_o),
        .invalid_o      (invalid_o),
        .overflow_o     (overflow_o)
    );

endmodule

// File: tb_fma.sv
`timescale 1ns/100ps
`include "fma_defines.svh"

module tb_fma;
    import fp_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int N_RAND     = 200;
    localparam int N_DIRECTED = 24;
    localparam int N_OPS      = N_RAND + N_DIRECTED;

    typedef struct packed {
        logic [`FMA_FP_WIDTH-1:0] res;
        logic [1:0]               rs;
        logic                     inv;
        logic                     ovf;
    } expect_t;

    logic                     clk_i;
    logic                     arst_n_i;
    logic                     valid_i;
    logic [`FMA_FP_WIDTH-1:0] a_i;
    logic [`FMA_FP_WIDTH-1:0] b_i;
    logic [`FMA_FP_WIDTH-1:0] c_i;
    logic                     sub_i;
    roundmode_e               rnd_i;
    logic                     valid_o;
    logic [`FMA_FP_WIDTH-1:0] result_o;
    logic [1:0]               round_sticky_o;
    logic                     invalid_o;
    logic                     overflow_o;

    expect_t     exp_q[$];
    expect_t     exp_rec;
    logic [31:0] lfsr_state = 32'h285a_a348;
    int          sent       = 0;
    int          received   = 0;

    fma_top dut_i (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .valid_i        (valid_i),
        .a_i            (a_i),
        .b_i            (b_i),
        .c_i            (c_i),
        .sub_i          (sub_i),
        .rnd_i          (rnd_i),
        .valid_o        (valid_o),
        .result_o       (result_o),
        .round_sticky_o (round_sticky_o),
        .invalid_o      (invalid_o),
        .overflow_o     (overflow_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expv,
                                   input logic [31:0] actv);
        stop_with_failure($sformatf("error %s expected %h actual %h", name, expv, actv));
    endtask

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            val        = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic int rand_operand();
        logic [7:0] v;
        v = 8'(next_bits(8));
        if (v == 8'd0)
            v = 8'd255;
        return int'(v);
    endfunction

    // exact for magnitudes below 2^24
    function automatic logic [31:0] int_to_fp32(input int v);
        logic [31:0] mag;
        logic [31:0] aligned;
        int          msb;
        mag = (v < 0) ? -v : v;
        msb = 0;
        for (int i = 0; i < 32; i++)
            if (mag[i])
                msb = i;
        aligned = mag << (23 - msb);
        return {v < 0, 8'(`FMA_BIAS + msb), aligned[22:0]};
    endfunction

    function automatic logic is_nan(input logic [31:0] x);
        return (&x[30:23]) && (x[22:0] != '0);
    endfunction

    function automatic logic is_snan(input logic [31:0] x);
        return is_nan(x) && !x[22];
    endfunction

    // first nan in a, b, c order, quieted
    function automatic logic [31:0] first_nan(input logic [31:0] a, b, c);
        if (is_nan(a))
            return a | 32'h0040_0000;
        else if (is_nan(b))
            return b | 32'h0040_0000;
        else
            return c | 32'h0040_0000;
    endfunction

    task automatic drive_op(input logic [31:0] a, b, c, input logic sub, input roundmode_e rnd,
                            input logic [31:0] res, input logic [1:0] rs, input logic inv, ovf);
        expect_t rec;
        rec     = '{res, rs, inv, ovf};
        a_i     = a;
        b_i     = b;
        c_i     = c;
        sub_i   = sub;
        rnd_i   = rnd;
        valid_i = 1'b1;
        exp_q.push_back(rec);
        sent++;
        @(posedge clk_i);
        #2;
    endtask

    task automatic drive_nan_op(input logic [31:0] a, b, c);
        drive_op(a, b, c, 1'b0, RNE, first_nan(a, b, c), 2'b00,
                 is_snan(a) | is_snan(b) | is_snan(c), 1'b0);
    endtask

    //////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////
    always @(negedge clk_i)
    begin
        if (arst_n_i && valid_o)
        begin
            if (exp_q.size() == 0)
                stop_with_failure("a result appeared with no operation pending");
            else
            begin
                exp_rec = exp_q.pop_front();
                received++;
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i) valid_i |-> ##2 valid_o)
        else stop_with_failure("valid_o did not follow valid_i after two cycles");
    assert property (@(posedge clk_i) disable iff (!arst_n_i) valid_o |-> $past(valid_i, 2))
        else stop_with_failure("valid_o was raised without an operation two cycles before");

    assert property (@(posedge clk_i) disable iff (!arst_n_i) valid_o |-> result_o == exp_rec.res)
        else report_mismatch("result_o", exp_rec.res, $sampled(result_o));
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_o |-> round_sticky_o == exp_rec.rs)
        else report_mismatch("round_sticky_o", exp_rec.rs, $sampled(round_sticky_o));
    assert property (@(posedge clk_i) disable iff (!arst_n_i) valid_o |-> invalid_o == exp_rec.inv)
        else report_mismatch("invalid_o", exp_rec.inv, $sampled(invalid_o));
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_o |-> overflow_o == exp_rec.ovf)
        else report_mismatch("overflow_o", exp_rec.ovf, $sampled(overflow_o));

    initial
    begin
        #(CLK_PERIOD * (N_OPS + 10));
        stop_with_failure("timeout while waiting for results");
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    initial
    begin
        int          av;
        int          bv;
        int          cv;
        int          sum;
        logic        sub;
        roundmode_e  rnd;
        logic [31:0] exp_res;
        arst_n_i = 1'b0;
        valid_i  = 1'b0;
        a_i      = '0;
        b_i      = '0;
        c_i      = '0;
        sub_i    = 1'b0;
        rnd_i    = RNE;
        repeat (2) @(posedge clk_i);
        assert (!valid_o && !invalid_o && !overflow_o)
            else stop_with_failure("outputs were not low during reset");
        #2;
        arst_n_i = 1'b1;
        @(posedge clk_i);
        #2;

        // exact integers, back to back
        for (int i = 0; i < N_RAND; i++)
        begin
            av  = rand_operand();
            bv  = rand_operand();
            cv  = rand_operand();
            sub = 1'(next_bits(1));
            rnd = roundmode_e'(3'(next_bits(3) % 5));
            sum = av * bv + (sub ? -cv : cv);
            if (sum == 0)
                exp_res = (rnd == RDN) ? 32'h8000_0000 : 32'h0000_0000;
            else
                exp_res = int_to_fp32(sum);
            drive_op(int_to_fp32(av), int_to_fp32(bv), int_to_fp32(cv), sub, rnd,
                     exp_res, 2'b00, 1'b0, 1'b0);
        end

        // round and sticky below 1.0
        drive_op(32'h3f80_0000, 32'h3f80_0000, 32'h3380_0000, 1'b0, RNE,
                 32'h3f80_0000, 2'b10, 1'b0, 1'b0);
        drive_op(32'h3f80_0000, 32'h3f80_0000, 32'h3300_0000, 1'b0, RNE,
                 32'h3f80_0000, 2'b01, 1'b0, 1'b0);
        drive_op(32'h3f80_0000, 32'h3f80_0000, 32'h3440_0000, 1'b0, RNE,
                 32'h3f80_0001, 2'b10, 1'b0, 1'b0);

        // exact cancellation, 3*5-15
        drive_op(32'h4040_0000, 32'h40a0_0000, 32'h4170_0000, 1'b1, RNE, 32'h0, 2'b00, 1'b0, 1'b0);
        drive_op(32'h4040_0000, 32'h40a0_0000, 32'h4170_0000, 1'b1, RDN,
                 32'h8000_0000, 2'b00, 1'b0, 1'b0);
        drive_op(32'hc040_0000, 32'h40a0_0000, 32'hc170_0000, 1'b1, RNE, 32'h0, 2'b00, 1'b0, 1'b0);
        drive_op(32'hc040_0000, 32'h40a0_0000, 32'hc170_0000, 1'b1, RDN,
                 32'h8000_0000, 2'b00, 1'b0, 1'b0);

        // nan propagation
        drive_nan_op(32'h7fc1_2345, 32'hffa0_0001, 32'h3f80_0000);
        drive_nan_op(32'h3f80_0000, 32'hff80_0123, 32'h7fc0_0000);
        drive_nan_op(32'h4000_0000, 32'h4040_0000, 32'h7f81_2345);
        drive_nan_op(32'h4000_0000, 32'h4040_0000, 32'hffc0_0042);
        drive_nan_op(32'h7fc0_0001, 32'h0000_0000, 32'h3f80_0000);

        // invalid operations, a subnormal counts as zero
        drive_op(32'h7f80_0000, 32'h0000_0000, 32'h3f80_0000, 1'b0, RNE,
                 `FMA_QNAN_INDEF, 2'b00, 1'b1, 1'b0);
        drive_op(32'h8000_0000, 32'hff80_0000, 32'h7fc0_0000, 1'b0, RNE,
                 `FMA_QNAN_INDEF, 2'b00, 1'b1, 1'b0);
        drive_op(32'h7f80_0000, 32'h0000_0001, 32'h4000_0000, 1'b0, RNE,
                 `FMA_QNAN_INDEF, 2'b00, 1'b1, 1'b0);
        drive_op(32'h7f80_0000, 32'h4000_0000, 32'h7f80_0000, 1'b1, RNE,
                 `FMA_QNAN_INDEF, 2'b00, 1'b1, 1'b0);
        drive_op(32'h7f80_0000, 32'h4000_0000, 32'hff80_0000, 1'b0, RNE,
                 `FMA_QNAN_INDEF, 2'b00, 1'b1, 1'b0);

        // overflow and infinities
        drive_op(32'h7180_0000, 32'h7180_0000, 32'h3f80_0000, 1'b0, RNE,
                 32'h7f80_0000, 2'b00, 1'b0, 1'b1);
        drive_op(32'hf180_0000, 32'h7180_0000, 32'h3f80_0000, 1'b0, RNE,
                 32'hff80_0000, 2'b00, 1'b0, 1'b1);
        drive_op(32'h7f80_0000, 32'h4000_0000, 32'h7f80_0000, 1'b0, RNE,
                 32'h7f80_0000, 2'b00, 1'b0, 1'b0);
        drive_op(32'h4000_0000, 32'h4040_0000, 32'hff80_0000, 1'b1, RNE,
                 32'h7f80_0000, 2'b00, 1'b0, 1'b0);
        drive_op(32'h4000_0000, 32'h4040_0000, 32'hff80_0000, 1'b0, RNE,
                 32'hff80_0000, 2'b00, 1'b0, 1'b0);

        // flush below range, zero product passes c through
        drive_op(32'h0d80_0000, 32'h0d80_0000, 32'h0000_0000, 1'b0, RNE,
                 32'h0000_0000, 2'b00, 1'b0, 1'b0);
        drive_op(32'h0000_0000, 32'h40a0_0000, 32'h3f80_0000, 1'b1, RNE,
                 32'hbf80_0000, 2'b00, 1'b0, 1'b0);

        valid_i = 1'b0;
        wait (received == sent);
        @(posedge clk_i);
        #1;
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: fma.f
+incdir+.
fp_pkg.sv
fma_pkg.sv
fma_prod_if.sv
lzc.sv
fma_mul_stage.sv
fma_add_stage.sv
fma_top.sv
tb_fma.sv
